// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

	import rv32i_types::*;
	import icache_types::*;

	localparam int n_random   = 240;
	localparam int n_directed = 40;
	// A miss with a six-cycle memory takes about ten cycles
	localparam int watchdog_cycles = 16 + (n_random + n_directed) * 12 + 400;

	logic        clk;
	logic        rst_n;
	logic        req_valid;
	rv32i_addr   req_addr;
	logic        req_ready;
	logic        resp_valid;
	rv32i_word   resp_data;
	pmem_req_t   pmem_req;
	logic        pmem_resp;
	cache_line_t pmem_rdata;
	logic [2:0]  resp_delay;

	integer      seed;
	int          data_errors;
	int          protocol_errors;
	int          responses;
	logic        take;
	rv32i_addr   exp_q[$];
	rv32i_addr   exp_front;
	int          exp_count;
	rv32i_addr   miss_line;
	logic [2:0]  mon_idx;

	// Shadow tags, valid bits and LRU, lru names the way to evict next
	logic [23:0] sh_tag [8][2];
	logic [1:0]  sh_valid [8];
	logic        sh_lru [8];
	logic        shadow_hit;
	logic        shadow_way;

	icache uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_addr   (req_addr),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_data  (resp_data),
		.pmem_req   (pmem_req),
		.pmem_resp  (pmem_resp),
		.pmem_rdata (pmem_rdata)
	);

	pmem_model memory (
		.clk        (clk),
		.rst_n      (rst_n),
		.pmem_req   (pmem_req),
		.resp_delay (resp_delay),
		.pmem_resp  (pmem_resp),
		.pmem_rdata (pmem_rdata)
	);

	always #20 clk = ~clk;

	function automatic rv32i_word content_word(input rv32i_addr a);
		return {a[31:2], 2'b00} ^ 32'hC0DE_0000;
	endfunction

	function automatic rv32i_addr line_of(input rv32i_addr a);
		return {a[31:5], 5'b00000};
	endfunction

	// Three tags over eight sets, so some sets see evictions
	function automatic rv32i_addr random_addr();
		logic [23:0] tag;
		case ($unsigned($random(seed)) % 3)
			0:       tag = 24'h000010;
			1:       tag = 24'h0A0B0C;
			default: tag = 24'h123456;
		endcase
		return {tag, 3'($random(seed)), 3'($random(seed)), 2'b00};
	endfunction

	task automatic send(input rv32i_addr a);
		req_valid  = 1'b1;
		req_addr   = a;
		resp_delay = 3'(1 + $unsigned($random(seed)) % 6);
		@(negedge clk);
		while (!req_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	task automatic pause(input int cycles);
		req_valid = 1'b0;
		repeat (cycles) begin
			@(posedge clk);
		end
		#2;
	endtask

	assign take = req_valid && req_ready;

	always_comb begin
		shadow_hit = 1'b0;
		shadow_way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (sh_valid[req_addr[7:5]][w] && sh_tag[req_addr[7:5]][w] == req_addr[31:8]) begin
				shadow_hit = 1'b1;
				shadow_way = w[0];
			end
		end
	end

	// Outstanding requests in order, and the shadow follows each accept
	always @(posedge clk) begin
		if (rst_n) begin
			if (resp_valid && exp_q.size() > 0) begin
				void'(exp_q.pop_front());
				responses++;
			end
			if (take) begin
				exp_q.push_back(req_addr);
				mon_idx = req_addr[7:5];
				if (shadow_hit) begin
					sh_lru[mon_idx] = !shadow_way;
				end else begin
					miss_line = line_of(req_addr);
					sh_tag[mon_idx][sh_lru[mon_idx]] = req_addr[31:8];
					sh_valid[mon_idx][sh_lru[mon_idx]] = 1'b1;
					sh_lru[mon_idx] = !sh_lru[mon_idx];
				end
			end
			exp_count = exp_q.size();
			exp_front = (exp_count > 0) ? exp_q[0] : '0;
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	a_reset_idle : assert property (@(posedge clk)
		$rose(rst_n) |-> !resp_valid && !pmem_req.read && req_ready
	) else begin
		protocol_errors++;
		$display("Error at %0t: cache outputs not idle after reset", $time);
	end

	a_resp_owed : assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid |-> exp_count != 0
	) else begin
		protocol_errors++;
		$display("Error at %0t: response with no request outstanding", $time);
	end

	a_resp_data : assert property (@(posedge clk) disable iff (!rst_n)
		resp_valid && exp_count != 0 |-> resp_data == content_word(exp_front)
	) else begin
		data_errors++;
		$display("Fail %0t: data %h for address %h, expected %h", $time,
			$sampled(resp_data), $sampled(exp_front), content_word($sampled(exp_front)));
	end

	a_hit_next : assert property (@(posedge clk) disable iff (!rst_n)
		take && shadow_hit |=> resp_valid && !pmem_req.read
	) else begin
		protocol_errors++;
		$display("Error at %0t: resident line did not respond in the next cycle", $time);
	end

	a_miss_read : assert property (@(posedge clk) disable iff (!rst_n)
		take && !shadow_hit |=> !resp_valid ##1 pmem_req.read
	) else begin
		protocol_errors++;
		$display("Error at %0t: absent line did not start a memory read", $time);
	end

	a_read_held : assert property (@(posedge clk) disable iff (!rst_n)
		pmem_req.read && !pmem_resp |=> pmem_req.read
	) else begin
		protocol_errors++;
		$display("Error at %0t: memory read dropped before the response", $time);
	end

	a_read_addr : assert property (@(posedge clk) disable iff (!rst_n)
		pmem_req.read |-> pmem_req.address == miss_line
	) else begin
		data_errors++;
		$display("Fail %0t: memory address %h, expected %h", $time,
			$sampled(pmem_req.address), $sampled(miss_line));
	end

	initial begin
		repeat (watchdog_cycles) begin
			@(posedge clk);
		end
		$display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		clk             = 1'b0;
		rst_n           = 1'b0;
		req_valid       = 1'b0;
		req_addr        = '0;
		resp_delay      = 3'd1;
		seed            = 32'h4572;
		data_errors     = 0;
		protocol_errors = 0;
		responses       = 0;
		exp_count       = 0;
		exp_front       = '0;
		miss_line       = '0;
		for (int s = 0; s < 8; s++) begin
			sh_valid[s]  = 2'b00;
			sh_lru[s]    = 1'b0;
			sh_tag[s][0] = '0;
			sh_tag[s][1] = '0;
		end
		repeat (16) begin
			@(posedge clk);
		end
		#2;
		rst_n = 1'b1;
		pause(2);

		// Cold miss with the next requests stalled behind it
		send(32'h0000_1000);
		send(32'h0000_1004);
		send(32'h0000_1008);
		send(32'h0000_101C);
		pause(3);

		for (int i = 0; i < 16; i++) begin
			send(32'h0000_1000 + 32'(4 * (i % 8)));
		end
		pause(3);

		// Three tags in set 2
		send(32'h0001_0040);
		pause(1);
		send(32'h0002_0040);
		send(32'h0001_0044);
		send(32'h0003_0048);
		pause(2);
		send(32'h0001_004C);
		send(32'h0002_0050);
		pause(3);

		for (int i = 0; i < n_random; i++) begin
			send(random_addr());
			if ($unsigned($random(seed)) % 4 == 0) begin
				pause(1 + $unsigned($random(seed)) % 3);
			end
		end
		pause(1);
		while (exp_count != 0) begin
			@(negedge clk);
		end
		pause(4);

		$display("Summary: %0d responses, %0d value errors, %0d protocol errors",
			responses, data_errors, protocol_errors);
		if (data_errors == 0 && protocol_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule : icache_tb

`default_nettype wire

// ==== bench/pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// Line memory behind the refill port, answers after resp_delay cycles
module pmem_model (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire icache_types::pmem_req_t   pmem_req,
	input  wire logic [2:0]                resp_delay,
	output logic                           pmem_resp,
	output icache_types::cache_line_t      pmem_rdata
);

	import rv32i_types::*;
	import icache_types::*;

	rv32i_addr line_addr;
	int        wait_cycles;

	// Every word holds its own byte address XOR a fixed pattern
	function automatic cache_line_t line_content(input rv32i_addr base);
		cache_line_t line;
		for (int i = 0; i < 8; i++) begin
			line[32*i +: 32] = (base + 32'(4 * i)) ^ 32'hC0DE_0000;
		end
		return line;
	endfunction

	initial begin
		pmem_resp  = 1'b0;
		pmem_rdata = '0;
		forever begin
			@(posedge clk);
			if (rst_n && pmem_req.read) begin
				line_addr   = pmem_req.address;
				wait_cycles = (resp_delay == 3'd0) ? 1 : int'(resp_delay);
				repeat (wait_cycles - 1) begin
					@(posedge clk);
				end
				#2;
				pmem_rdata = line_content(line_addr);
				pmem_resp  = 1'b1;
				@(posedge clk);
				#2;
				pmem_resp  = 1'b0;
				pmem_rdata = '0;
			end
		end
	end

endmodule : pmem_model

`default_nettype wire

// ==== hdl/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register file with a registered read port and a separate write port
module cache_array #(
	parameter int s_width = 1,
	parameter int s_index = 3
) (
	input  wire logic               clk,
	input  wire logic               rst_n,
	input  wire logic               read,
	input  wire logic               load,
	input  wire logic [s_index-1:0] rindex,
	input  wire logic [s_index-1:0] windex,
	input  wire logic [s_width-1:0] datain,
	output logic      [s_width-1:0] dataout
);

	localparam int num_sets = 2**s_index;

	logic [s_width-1:0] data [num_sets];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < num_sets; i++) begin
				data[i] <= '0;
			end
			dataout <= '0;
		end else begin
			// Same-edge write to the set being read is forwarded
			if (read) begin
				if (load && (windex == rindex)) begin
					dataout <= datain;
				end else begin
					dataout <= data[rindex];
				end
			end
			if (load) begin
				data[windex] <= datain;
			end
		end
	end

endmodule : cache_array

`default_nettype wire

// ==== hdl/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      req_valid,
	input  wire rv32i_types::rv32i_addr    req_addr,
	output logic                           req_ready,
	output logic                           resp_valid,
	output rv32i_types::rv32i_word         resp_data,
	output icache_types::pmem_req_t        pmem_req,
	input  wire logic                      pmem_resp,
	input  wire icache_types::cache_line_t pmem_rdata
);

	import rv32i_types::*;
	import icache_types::*;

	logic      req_take;
	logic      load_stage;
	way_mask_t load_tag;
	way_mask_t load_data;
	way_mask_t set_valid;
	logic      load_lru;
	logic      latch_fill;
	logic      use_fill;
	logic      stage_fetch;
	logic      hit;
	logic      lru_way;
	logic      pmem_read;
	rv32i_addr pmem_address;

	icache_control control (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.stage_fetch (stage_fetch),
		.hit         (hit),
		.lru_way     (lru_way),
		.pmem_resp   (pmem_resp),
		.req_ready   (req_ready),
		.req_take    (req_take),
		.resp_valid  (resp_valid),
		.pmem_read   (pmem_read),
		.load_stage  (load_stage),
		.load_tag    (load_tag),
		.load_data   (load_data),
		.set_valid   (set_valid),
		.load_lru    (load_lru),
		.latch_fill  (latch_fill),
		.use_fill    (use_fill)
	);

	icache_dp datapath (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_addr     (req_addr),
		.req_take     (req_take),
		.load_stage   (load_stage),
		.load_tag     (load_tag),
		.load_data    (load_data),
		.set_valid    (set_valid),
		.load_lru     (load_lru),
		.latch_fill   (latch_fill),
		.use_fill     (use_fill),
		.pmem_rdata   (pmem_rdata),
		.resp_data    (resp_data),
		.pmem_address (pmem_address),
		.stage_fetch  (stage_fetch),
		.hit          (hit),
		.lru_way      (lru_way)
	);

	assign pmem_req = pmem_req_t'{read: pmem_read, address: pmem_address};

endmodule : icache

`default_nettype wire

// ==== hdl/icache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_control (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             req_valid,
	input  wire logic             stage_fetch,
	input  wire logic             hit,
	input  wire logic             lru_way,
	input  wire logic             pmem_resp,
	output logic                  req_ready,
	output logic                  req_take,
	output logic                  resp_valid,
	output logic                  pmem_read,
	output logic                  load_stage,
	output icache_types::way_mask_t load_tag,
	output icache_types::way_mask_t load_data,
	output icache_types::way_mask_t set_valid,
	output logic                  load_lru,
	output logic                  latch_fill,
	output logic                  use_fill
);

	import icache_types::*;

	typedef enum logic [1:0] {
		run,
		fetch,
		fill,
		respond
	} state_t;

	state_t    state;
	state_t    state_next;
	logic      stall;
	logic      fill_done;
	way_mask_t fill_mask;

	// Request in stage 2 that is not resident
	assign stall     = stage_fetch && !hit;
	assign fill_done = (state == fetch) && pmem_resp;
	assign fill_mask = fill_done ? way_onehot(lru_way) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= run;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		unique case (state)
			run:     if (stall) state_next = fetch;
			fetch:   if (pmem_resp) state_next = fill;
			fill:    state_next = respond;
			respond: state_next = run;
			default: state_next = run;
		endcase
	end

	// ------------------------------------------------------------------------
	// Outputs
	// ------------------------------------------------------------------------
	always_comb begin
		req_ready  = 1'b0;
		resp_valid = 1'b0;
		load_stage = 1'b0;
		use_fill   = 1'b0;
		unique case (state)
			run: begin
				req_ready  = !stall;
				resp_valid = stage_fetch && hit;
				load_stage = !stall;
			end
			// Replay the array read for the held address
			fill: begin
				load_stage = 1'b1;
			end
			respond: begin
				req_ready  = 1'b1;
				resp_valid = 1'b1;
				load_stage = 1'b1;
				use_fill   = 1'b1;
			end
			default: begin
				req_ready = 1'b0;
			end
		endcase
	end

	assign req_take   = req_valid && req_ready;
	assign pmem_read  = (state == fetch);
	assign load_tag   = fill_mask;
	assign load_data  = fill_mask;
	assign set_valid  = fill_mask;
	assign latch_fill = fill_done;
	assign load_lru   = fill_done || ((state == run) && stage_fetch && hit);

	a_read_held : assert property (
		@(posedge clk) disable iff (!rst_n)
		pmem_read && !pmem_resp |=> pmem_read
	) else $error("memory read dropped before response");

	// No response between a miss and its fill response
	a_no_resp_in_miss : assert property (
		@(posedge clk) disable iff (!rst_n)
		(state == run) && stall |=> !resp_valid until (state == respond)
	) else $error("response raised while a miss is outstanding");

endmodule : icache_control

`default_nettype wire

// ==== hdl/icache_dp.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_dp (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire rv32i_types::rv32i_addr  req_addr,
	input  wire logic                    req_take,
	input  wire logic                    load_stage,
	input  wire icache_types::way_mask_t load_tag,
	input  wire icache_types::way_mask_t load_data,
	input  wire icache_types::way_mask_t set_valid,
	input  wire logic                    load_lru,
	input  wire logic                    latch_fill,
	input  wire logic                    use_fill,
	input  wire icache_types::cache_line_t pmem_rdata,
	output rv32i_types::rv32i_word       resp_data,
	output rv32i_types::rv32i_addr       pmem_address,
	output logic                         stage_fetch,
	output logic                         hit,
	output logic                         lru_way
);

	import rv32i_types::*;
	import icache_types::*;

	cache_cw_t    cw_next;
	cache_cw_t    stage;
	cache_index_t rindex;
	cache_index_t windex;
	cache_tag_t   stage_tag;
	word_sel_t    word_sel;

	cache_tag_t  tag_out [2];
	cache_line_t line_out [2];
	way_mask_t   valid_out;
	way_mask_t   way_hit;
	logic        lru_out;
	logic        lru_in;

	cache_line_t fill_line;
	cache_line_t sel_line;
	rv32i_word [7:0] line_words;

	// ------------------------------------------------------------------------
	// Stage 1: next control word and array read index
	// ------------------------------------------------------------------------

	// Without a new request the held address is re-read, which also
	// serves as the replay after a fill
	always_comb begin
		cw_next.address = req_take ? req_addr : stage.address;
		cw_next.fetch   = req_take;
	end

	assign rindex = addr_index(cw_next.address);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage <= '0;
		end else if (load_stage) begin
			stage <= cw_next;
		end
	end

	assign stage_fetch = stage.fetch;
	assign windex      = addr_index(stage.address);
	assign stage_tag   = addr_tag(stage.address);
	assign word_sel    = addr_word(stage.address);

	// ------------------------------------------------------------------------
	// Arrays
	// ------------------------------------------------------------------------
	for (genvar w = 0; w < 2; w++) begin : g_way
		cache_array #(.s_width(s_tag), .s_index(s_index)) tag_array (
			.clk     (clk),
			.rst_n   (rst_n),
			.read    (load_stage),
			.load    (load_tag[w]),
			.rindex  (rindex),
			.windex  (windex),
			.datain  (stage_tag),
			.dataout (tag_out[w])
		);

		cache_array #(.s_width(1), .s_index(s_index)) valid_array (
			.clk     (clk),
			.rst_n   (rst_n),
			.read    (load_stage),
			.load    (set_valid[w]),
			.rindex  (rindex),
			.windex  (windex),
			.datain  (1'b1),
			.dataout (valid_out[w])
		);

		cache_array #(.s_width(s_line), .s_index(s_index)) line_array (
			.clk     (clk),
			.rst_n   (rst_n),
			.read    (load_stage),
			.load    (load_data[w]),
			.rindex  (rindex),
			.windex  (windex),
			.datain  (pmem_rdata),
			.dataout (line_out[w])
		);

		assign way_hit[w] = valid_out[w] && (tag_out[w] == stage_tag);
	end

	cache_array #(.s_width(1), .s_index(s_index)) lru_array (
		.clk     (clk),
		.rst_n   (rst_n),
		.read    (load_stage),
		.load    (load_lru),
		.rindex  (rindex),
		.windex  (windex),
		.datain  (lru_in),
		.dataout (lru_out)
	);

	// ------------------------------------------------------------------------
	// Stage 2: compare, replacement and word select
	// ------------------------------------------------------------------------
	assign hit     = |way_hit;
	assign lru_way = lru_out;

	// LRU bit names the way to evict next
	assign lru_in = (|set_valid) ? set_valid[0] : way_hit[0];

	always_ff @(posedge clk) begin
		if (latch_fill) begin
			fill_line <= pmem_rdata;
		end
	end

	always_comb begin
		if (use_fill) begin
			sel_line = fill_line;
		end else if (way_hit[1]) begin
			sel_line = line_out[1];
		end else begin
			sel_line = line_out[0];
		end
	end

	// Word 0 sits in the low bits of the line
	assign line_words   = sel_line;
	assign resp_data    = line_words[word_sel];
	assign pmem_address = line_base(stage.address);

	a_one_way_hit : assert property (
		@(posedge clk) disable iff (!rst_n)
		stage.fetch |-> !(way_hit[0] && way_hit[1])
	) else $error("tag present in both ways of set %0d", windex);

endmodule : icache_dp

`default_nettype wire

// ==== hdl/icache_types.sv ====
`default_nettype none

package icache_types;

	// ------------------------------------------------------------------------
	// Geometry: 8 sets, two ways, 32-byte lines
	// ------------------------------------------------------------------------
	localparam int s_offset = 5;
	localparam int s_index  = 3;
	localparam int s_tag    = 24;
	localparam int s_line   = 256;

	typedef logic [s_index-1:0] cache_index_t;
	typedef logic [s_tag-1:0]   cache_tag_t;
	typedef logic [s_line-1:0]  cache_line_t;
	typedef logic [2:0]         word_sel_t;

	// One bit per way, used for the per-way write strobes
	typedef logic [1:0] way_mask_t;

	// Travels from stage 1 to stage 2
	typedef struct packed {
		rv32i_types::rv32i_addr address;
		logic                   fetch;
	} cache_cw_t;

	typedef struct packed {
		logic                   read;
		rv32i_types::rv32i_addr address;
	} pmem_req_t;

	// Address fields
	function automatic cache_index_t addr_index(input rv32i_types::rv32i_addr a);
		return a[s_offset +: s_index];
	endfunction

	function automatic cache_tag_t addr_tag(input rv32i_types::rv32i_addr a);
		return a[31 -: s_tag];
	endfunction

	function automatic word_sel_t addr_word(input rv32i_types::rv32i_addr a);
		return a[s_offset-1:2];
	endfunction

	function automatic rv32i_types::rv32i_addr line_base(input rv32i_types::rv32i_addr a);
		return {a[31:s_offset], {s_offset{1'b0}}};
	endfunction

	function automatic way_mask_t way_onehot(input logic way);
		return way ? 2'b10 : 2'b01;
	endfunction

endpackage : icache_types

`default_nettype wire

// ==== hdl/rv32i_types.sv ====
`default_nettype none

// Core-side types shared by the cache and its clients
package rv32i_types;

	// Instruction or data word as seen by the core
	typedef logic [31:0] rv32i_word;

	// Byte address on the fetch port
	typedef logic [31:0] rv32i_addr;

endpackage : rv32i_types

`default_nettype wire

// ==== verilog.f ====
hdl/rv32i_types.sv
hdl/icache_types.sv
hdl/cache_array.sv
hdl/icache_dp.sv
hdl/icache_control.sv
hdl/icache.sv
bench/pmem_model.sv
bench/icache_tb.sv
